// ==== verilog/zx_ports_pkg.sv ====
// shared types and constants for the port block
// only the low address byte is decoded, high bits qualify a few ports
// bit positions follow the pentagon/zx-evo paging layout

package zx_ports_pkg;

	typedef logic [7:0] zx_byte_t; // z80 data byte

	//////////////////////////////////////////////////////////////
	// low address byte of the decoded ports
	//////////////////////////////////////////////////////////////

	typedef enum logic [7:0]
	{
		PORT_FE     = 8'hFE, // keyboard, tape, border, beeper
		PORT_F6     = 8'hF6, // alias of FE
		PORT_FD     = 8'hFD, // 7ffd paging and ay
		PORT_F7     = 8'hF7, // eff7
		PORT_KJOY   = 8'h1F, // kempston joystick
		PORT_KMOUSE = 8'hDF, // kempston mouse
		PORT_SDCFG  = 8'h77, // sd config
		PORT_SDDAT  = 8'h57, // sd data
		PORT_VGSYS  = 8'hFF  // beta system port, not served here
	} port_addr_e;

	//////////////////////////////////////////////////////////////
	// register fields
	//////////////////////////////////////////////////////////////

	// 7ffd
	localparam int P7FFD_LOCK_BIT = 5; // 48k lock, only with block1m
	localparam int P7FFD_ROM_BIT  = 4; // rom select

	// eff7
	localparam int PEFF7_BLOCK1M_BIT = 2; // 1 = pentagon-1m paging off
	localparam int PEFF7_RAM0_BIT    = 3; // ram page 0 at 0000

	// reset and idle values
	localparam logic     SDCS_RESET = 1'b1;  // card deselected
	localparam zx_byte_t IDLE_BYTE  = 8'hFF; // floating bus

endpackage

// ==== verilog/port_bus_if.sv ====
// decoded i/o access, from the decoder to the register units
// wr and rd are single zclk pulses per z80 i/o cycle
// wr_lvl and rd_lvl are the raw combinational access levels

interface port_bus_if #(
	parameter int ADDR_W = 16
);

	logic [ADDR_W-1:0] addr;  // full z80 address
	logic [7:0]        data;  // write byte from z80
	logic              wr;    // write strobe, one cycle
	logic              rd;    // read strobe, one cycle
	logic              shadow; // dos / shadow ports on
	logic              wr_lvl; // iorq & wr, unregistered
	logic              rd_lvl; // iorq & rd, unregistered

	// decoder side drives everything
	modport decoder (
		output addr, data, wr, rd, shadow, wr_lvl, rd_lvl
	);

	// register units only look
	modport unit (
		input addr, data, wr, rd, shadow, wr_lvl, rd_lvl
	);

endinterface

// ==== verilog/io_decode.sv ====
// z80 i/o strobe generation and low byte decode on zclk only
// strobes come out one cycle after the first edge that sees the access
// dout follows the address and dataout says when to drive it

module io_decode import zx_ports_pkg::*; #(
	parameter int ADDR_W = 16
) (
	input  logic              zclk,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic [ADDR_W-1:0] a,
	input  zx_byte_t          din,
	input  logic              dos,
	input  logic [4:0]        keys_in,    // fe keyboard columns
	input  logic [4:0]        kj_in,      // joystick
	input  zx_byte_t          mus_in,     // mouse
	input  logic              tape_read,
	input  zx_byte_t          sd_dataout, // last spi byte
	output logic              porthit,
	output logic              dataout,
	output zx_byte_t          dout,
	port_bus_if.decoder       bus
);

	logic       wr_act, rd_act; // access levels now
	logic       wr_seen, rd_seen; // levels at last edge
	logic       ay_data_rd;       // fffd read, answered by the ay itself
	port_addr_e loa;

	assign loa    = port_addr_e'(a[7:0]);
	assign wr_act = ~(iorq_n | wr_n);
	assign rd_act = ~(iorq_n | rd_n);

	//////////////////////////////////////////////////////////////
	// strobes
	//////////////////////////////////////////////////////////////

	always_ff @(posedge zclk)
	begin
		wr_seen <= wr_act;
		rd_seen <= rd_act;
		bus.wr  <= wr_act & ~wr_seen; // rising of access only
		bus.rd  <= rd_act & ~rd_seen;
	end

	assign bus.addr   = a;
	assign bus.data   = din;
	assign bus.shadow = dos; // shadow is dos alone here
	assign bus.wr_lvl = wr_act;
	assign bus.rd_lvl = rd_act;

	//////////////////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////////////////

	always_comb
	begin
		case (loa)
			PORT_FE, PORT_F6, PORT_FD, PORT_KMOUSE, PORT_SDDAT:
				porthit = 1'b1;
			PORT_KJOY, PORT_F7, PORT_SDCFG:
				porthit = ~dos; // these belong to beta/atm in shadow
			default:
				porthit = 1'b0;
		endcase
	end

	assign ay_data_rd = (loa == PORT_FD) && (a[15:14] == 2'b11);
	assign dataout    = porthit & rd_act & ~ay_data_rd;

	// read data
	always_comb
	begin
		case (loa)
			PORT_FE, PORT_F6: dout = {1'b1, tape_read, 1'b0, keys_in};
			PORT_KJOY:        dout = {3'b000, kj_in};
			PORT_KMOUSE:      dout = mus_in;
			PORT_SDCFG:       dout = 8'h00; // card present and not write protected
			PORT_SDDAT:       dout = sd_dataout;
			default:          dout = IDLE_BYTE;
		endcase
	end

endmodule

// ==== verilog/paging_regs.sv ====
// 7ffd / eff7 paging registers with the pentagon-1m extension
// eff7 bit 2 set means classic 128k paging, 7ffd bit 5 then locks
// rom bit follows rstrom[0] until two edges after reset release

module paging_regs import zx_ports_pkg::*; (
	input  logic        zclk,
	input  logic        rst_n,
	input  logic [1:0]  rstrom,       // boot rom select, bit 0 used
	port_bus_if.unit    bus,
	output zx_byte_t    p7ffd,
	output zx_byte_t    peff7,
	output logic [5:0]  pent1m_page,  // 1m page number
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0
);

	zx_byte_t   p7ffd_int, peff7_int;
	logic       p7ffd_rom; // rom bit, loaded at reset
	logic       rst_s1, rst_s2; // reset release sync
	logic       block1m, block7ffd;
	logic       wr_7ffd, wr_eff7;
	port_addr_e loa;

	assign loa = port_addr_e'(bus.addr[7:0]);

	assign block1m   = peff7_int[PEFF7_BLOCK1M_BIT];
	assign block7ffd = p7ffd_int[P7FFD_LOCK_BIT] & block1m;

	assign wr_7ffd = bus.wr && (loa == PORT_FD) && !bus.addr[15] && !block7ffd;
	// eff7 only outside shadow, a12 low, a8 high
	assign wr_eff7 = bus.wr && (loa == PORT_F7) && !bus.addr[12] && bus.addr[8] &&
		!bus.shadow;

	//////////////////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////////////////

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_int <= '0;
			peff7_int <= '0;
		end
		else
		begin
			if (wr_7ffd)
				p7ffd_int <= bus.data; // 2:0 page, 3 screen, 4 rom, 5 lock
			if (wr_eff7)
				peff7_int <= bus.data;
		end
	end

	// reset release seen twice before rom bit becomes writable
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rst_s1 <= 1'b1;
			rst_s2 <= 1'b1;
		end
		else
		begin
			rst_s1 <= 1'b0;
			rst_s2 <= rst_s1;
		end
	end

	always_ff @(posedge zclk)
	begin
		if (rst_s2)
			p7ffd_rom <= rstrom[0];
		else if (wr_7ffd)
			p7ffd_rom <= bus.data[P7FFD_ROM_BIT];
	end

	//////////////////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////////////////

	always_comb
	begin
		p7ffd                = p7ffd_int;
		p7ffd[P7FFD_ROM_BIT] = p7ffd_rom;
		peff7                = peff7_int;
		if (block1m)
		begin
			p7ffd[7:5] = 3'b000; // no 1m page bits in 128k mode
			peff7[6]   = 1'b0;
			peff7[3:1] = 3'b000;
		end
	end

	assign pent1m_page   = {p7ffd_int[7:5], p7ffd_int[2:0]};
	assign pent1m_rom    = p7ffd_int[P7FFD_ROM_BIT];
	assign pent1m_1m_on  = ~peff7_int[PEFF7_BLOCK1M_BIT];
	assign pent1m_ram0_0 = peff7_int[PEFF7_RAM0_BIT];

endmodule

// ==== verilog/audio_border.sv ====
// border colour, beeper write pulse and ay bus control
// ay lines follow the raw access, not the strobes

module audio_border import zx_ports_pkg::*; (
	input  logic       zclk,
	input  logic       rst_n,
	port_bus_if.unit   bus,
	output logic [3:0] border,    // {bright-ish a3, colour}
	output logic       beeper_wr, // one cycle, fe only
	output logic       ay_bc1,
	output logic       ay_bdir
);

	logic       fe_wr;
	logic       fd_hit;
	port_addr_e loa;

	assign loa    = port_addr_e'(bus.addr[7:0]);
	assign fe_wr  = bus.wr && ((loa == PORT_FE) || (loa == PORT_F6));
	assign fd_hit = (loa == PORT_FD);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			border <= 4'h0;
		else if (fe_wr)
			border <= {~bus.addr[3], bus.data[2:0]};
	end

	assign beeper_wr = bus.wr && (loa == PORT_FE); // f6 leaves beeper alone

	// fffd: register select / read, bffd: data write
	assign ay_bc1  = fd_hit && (bus.addr[15:14] == 2'b11) && (bus.rd_lvl || bus.wr_lvl);
	assign ay_bdir = fd_hit && bus.addr[15] && bus.wr_lvl; // 11 and 10 both

endmodule

// ==== verilog/sd_card_ctrl.sv ====
// sd card port pair, z-controller compatible
// in shadow, 57 with a15 high becomes the config port
// sd_start is a zclk pulse, spi engine must run on the same clock

module sd_card_ctrl import zx_ports_pkg::*; (
	input  logic     zclk,
	input  logic     rst_n,
	port_bus_if.unit bus,
	output logic     sdcs_n,
	output logic     sd_start,  // kick one spi byte
	output zx_byte_t sd_datain  // byte to shift out
);

	logic       cfg_wr, dat_wr, dat_rd;
	port_addr_e loa;

	assign loa = port_addr_e'(bus.addr[7:0]);

	//////////////////////////////////////////////////////////////
	// access decode
	//////////////////////////////////////////////////////////////

	assign cfg_wr = bus.wr && (
		((loa == PORT_SDCFG) && !bus.shadow) ||
		((loa == PORT_SDDAT) && bus.shadow && bus.addr[15]));

	assign dat_wr = bus.wr && (loa == PORT_SDDAT) && (!bus.shadow || !bus.addr[15]);
	assign dat_rd = bus.rd && (loa == PORT_SDDAT); // any read starts a transfer

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			sdcs_n <= SDCS_RESET;
		else if (cfg_wr)
			sdcs_n <= bus.data[1]; // bit 1 is cs
	end

	assign sd_start = dat_wr | dat_rd;

	// reads shift out ff
	assign sd_datain = bus.wr_lvl ? bus.data : IDLE_BYTE;

endmodule

// ==== verilog/zx_ports.sv ====
// spectrum i/o port block, single zclk domain
// no wait states, the z80 cycle paces every access

module zx_ports import zx_ports_pkg::*; #(
	parameter int ADDR_W = 16
) (
	input  logic              zclk,
	input  logic              rst_n,
	input  zx_byte_t          din,
	input  logic [ADDR_W-1:0] a,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              dos,
	input  logic [1:0]        rstrom,
	input  logic [4:0]        keys_in,
	input  logic [4:0]        kj_in,
	input  zx_byte_t          mus_in,
	input  logic              tape_read,
	input  zx_byte_t          sd_dataout,
	output zx_byte_t          dout,
	output logic              dataout,
	output logic              porthit,
	output logic [3:0]        border,
	output logic              beeper_wr,
	output logic              ay_bc1,
	output logic              ay_bdir,
	output zx_byte_t          p7ffd,
	output zx_byte_t          peff7,
	output logic [5:0]        pent1m_page,
	output logic              pent1m_rom,
	output logic              pent1m_1m_on,
	output logic              pent1m_ram0_0,
	output logic              sdcs_n,
	output logic              sd_start,
	output zx_byte_t          sd_datain
);

	port_bus_if #(.ADDR_W(ADDR_W)) bus ();

	// strobes, decode, read mux
	io_decode #(.ADDR_W(ADDR_W)) u_decode (
		.zclk(zclk), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .a(a), .din(din),
		.dos(dos), .keys_in(keys_in), .kj_in(kj_in), .mus_in(mus_in),
		.tape_read(tape_read), .sd_dataout(sd_dataout),
		.porthit(porthit), .dataout(dataout), .dout(dout), .bus(bus)
	);

	paging_regs u_paging (
		.zclk(zclk), .rst_n(rst_n), .rstrom(rstrom), .bus(bus),
		.p7ffd(p7ffd), .peff7(peff7), .pent1m_page(pent1m_page),
		.pent1m_rom(pent1m_rom), .pent1m_1m_on(pent1m_1m_on),
		.pent1m_ram0_0(pent1m_ram0_0)
	);

	audio_border u_audio (
		.zclk(zclk), .rst_n(rst_n), .bus(bus), .border(border),
		.beeper_wr(beeper_wr), .ay_bc1(ay_bc1), .ay_bdir(ay_bdir)
	);

	sd_card_ctrl u_sd (
		.zclk(zclk), .rst_n(rst_n), .bus(bus),
		.sdcs_n(sdcs_n), .sd_start(sd_start), .sd_datain(sd_datain)
	);

endmodule

// ==== bench/tb_zx_ports.sv ====
// reads bench/zx_ports_stim.txt relative to the project root
// each entry is one bus cycle held 4 zclk cycles and then 2 idle cycles
// rstrom tied to 01 so the rom bit reads 1 after reset

module tb_zx_ports;

	localparam int PERIOD    = 4;
	localparam int MAX_LINES = 64;

	logic       zclk, rst_n;
	logic [7:0] din, mus_in, sd_dataout;
	logic [15:0] a;
	logic       iorq_n, rd_n, wr_n, dos, tape_read;
	logic [1:0] rstrom;
	logic [4:0] keys_in, kj_in;
	logic [7:0] dout, p7ffd, peff7, sd_datain;
	logic       dataout, porthit, beeper_wr, ay_bc1, ay_bdir;
	logic [3:0] border;
	logic [5:0] pent1m_page;
	logic       pent1m_rom, pent1m_1m_on, pent1m_ram0_0, sdcs_n, sd_start;

	// stimulus table with one entry per file line
	logic [7:0]  op_t [MAX_LINES];
	logic [15:0] addr_t [MAX_LINES];
	logic [7:0]  data_t [MAX_LINES], mus_t [MAX_LINES], sddo_t [MAX_LINES];
	logic [7:0]  exp_t [MAX_LINES];
	logic [4:0]  keys_t [MAX_LINES], kj_t [MAX_LINES];
	logic        dos_t [MAX_LINES], tape_t [MAX_LINES];
	logic [3:0]  chk_t [MAX_LINES]; // which signal to compare

	int   nlines = 0;
	int   errors = 0;
	int   checks = 0;
	logic loaded = 1'b0;
	logic fd_written = 1'b0; // some 7ffd write since reset

	zx_ports #(.ADDR_W(16)) u_dut (
		.zclk(zclk), .rst_n(rst_n), .din(din), .a(a), .iorq_n(iorq_n), .rd_n(rd_n),
		.wr_n(wr_n), .dos(dos), .rstrom(rstrom), .keys_in(keys_in), .kj_in(kj_in),
		.mus_in(mus_in), .tape_read(tape_read), .sd_dataout(sd_dataout),
		.dout(dout), .dataout(dataout), .porthit(porthit), .border(border),
		.beeper_wr(beeper_wr), .ay_bc1(ay_bc1), .ay_bdir(ay_bdir), .p7ffd(p7ffd),
		.peff7(peff7), .pent1m_page(pent1m_page), .pent1m_rom(pent1m_rom),
		.pent1m_1m_on(pent1m_1m_on), .pent1m_ram0_0(pent1m_ram0_0),
		.sdcs_n(sdcs_n), .sd_start(sd_start), .sd_datain(sd_datain)
	);

	initial
	begin
		zclk = 1'b0;
		forever
			#(PERIOD / 2) zclk = ~zclk;
	end

	// run limit scales with the number of entries
	initial
	begin
		wait (loaded);
		#((nlines * 6 + 40) * PERIOD);
		$display("watchdog expired, the stimulus did not finish in time");
		$display("CHECKS FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////

	function automatic string sig_name(input logic [3:0] chk);
		case (chk)
			4'h1: sig_name = "dout";
			4'h2: sig_name = "porthit/dataout";
			4'h3: sig_name = "ay_bc1/ay_bdir";
			4'h4: sig_name = "sd_datain";
			4'h5: sig_name = "sd_start pulses";
			4'h6: sig_name = "beeper_wr pulses";
			4'h7: sig_name = "border";
			4'h8: sig_name = "p7ffd";
			4'h9: sig_name = "peff7";
			4'ha: sig_name = "sdcs_n";
			4'hb: sig_name = "pent1m_1m_on/pent1m_ram0_0";
			4'hc: sig_name = "pent1m_page";
			4'hd: sig_name = "pent1m_rom";
			default: sig_name = "unknown";
		endcase
	endfunction

	function automatic logic [7:0] observe(input logic [3:0] chk);
		case (chk)
			4'h1: observe = dout;
			4'h2: observe = {6'd0, porthit, dataout};
			4'h3: observe = {6'd0, ay_bc1, ay_bdir};
			4'h4: observe = sd_datain;
			4'h7: observe = {4'd0, border};
			4'h8: observe = p7ffd;
			4'h9: observe = peff7;
			4'ha: observe = {7'd0, sdcs_n};
			4'hb: observe = {6'd0, pent1m_1m_on, pent1m_ram0_0};
			4'hc: observe = {2'd0, pent1m_page};
			4'hd: observe = {7'd0, pent1m_rom};
			default: observe = 8'h00;
		endcase
	endfunction

	task automatic compare(input int n, input logic [3:0] chk, input logic [7:0] expv,
		input logic [7:0] got);
		checks++;
		if (got !== expv)
		begin
			errors++;
			$display("[FAIL] t=%0t entry %0d %s expected %02h got %02h", $time, n,
				sig_name(chk), expv, got);
		end
	endtask

	task automatic load_stim;
		int    fd;
		int    rc;
		string line;
		fd = $fopen("bench/zx_ports_stim.txt", "r");
		if (fd == 0)
			$display("cannot open the stimulus file bench/zx_ports_stim.txt");
		else
		begin
			while (!$feof(fd) && nlines < MAX_LINES)
			begin
				rc = $fgets(line, fd);
				if (rc > 0 && line.len() > 8 && line[0] != "#") // skip header and blanks
				begin
					rc = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h", op_t[nlines],
						addr_t[nlines], data_t[nlines], dos_t[nlines], keys_t[nlines],
						kj_t[nlines], mus_t[nlines], tape_t[nlines], sddo_t[nlines],
						exp_t[nlines], chk_t[nlines]);
					if (rc == 11)
						nlines++;
					else
					begin
						errors++;
						$display("malformed stimulus line after entry %0d", nlines);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// one bus cycle of 4 active cycles and 2 idle ones
	task automatic run_line(input int n);
		int pulses;
		pulses     = 0;
		a          = addr_t[n];
		din        = data_t[n];
		dos        = dos_t[n];
		keys_in    = keys_t[n];
		kj_in      = kj_t[n];
		mus_in     = mus_t[n];
		tape_read  = tape_t[n];
		sd_dataout = sddo_t[n];
		iorq_n     = (op_t[n] == "X");
		rd_n       = (op_t[n] != "R");
		wr_n       = (op_t[n] != "W");
		// first 7ffd write after reset is never locked
		if (op_t[n] == "W" && addr_t[n][7:0] == 8'hfd && !addr_t[n][15])
			fd_written = 1'b1;
		for (int i = 0; i < 4; i++)
		begin
			@(negedge zclk);
			if (chk_t[n] == 4'h5 && sd_start)
				pulses++;
			if (chk_t[n] == 4'h6 && beeper_wr)
				pulses++;
			if (i == 1 && chk_t[n] >= 4'h1 && chk_t[n] <= 4'h4) // combinational outputs
				compare(n, chk_t[n], exp_t[n], observe(chk_t[n]));
		end
		if (chk_t[n] == 4'h5 || chk_t[n] == 4'h6)
			compare(n, chk_t[n], exp_t[n], pulses[7:0]);
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		for (int i = 0; i < 2; i++)
		begin
			@(negedge zclk);
			compare(n, 4'h3, 8'h00, {6'd0, ay_bc1, ay_bdir}); // ay quiet when idle
			compare(n, 4'h5, 8'h00, {7'd0, sd_start});
		end
		if (chk_t[n] >= 4'h7) // registers settled by now
			compare(n, chk_t[n], exp_t[n], observe(chk_t[n]));
		// 1m rom bit is written 7ffd data only, 0 from reset
		if (chk_t[n] == 4'h8)
			compare(n, 4'hd, fd_written ? {7'd0, exp_t[n][4]} : 8'h00, observe(4'hd));
	endtask

	//////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////

	initial
	begin
		rst_n      = 1'b0;
		iorq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		a          = 16'h0000;
		din        = 8'h00;
		dos        = 1'b0;
		rstrom     = 2'b01;
		keys_in    = 5'h1f;
		kj_in      = 5'h00;
		mus_in     = 8'hff;
		tape_read  = 1'b0;
		sd_dataout = 8'hff;
		load_stim();
		loaded = 1'b1;
		if (nlines == 0)
			$display("no stimulus entries were read");
		else
		begin
			repeat (16) @(negedge zclk);
			rst_n = 1'b1;
			for (int i = 0; i < nlines; i++)
				run_line(i);
		end
		$display("entries: %0d, checks: %0d, errors: %0d", nlines, checks, errors);
		if (nlines > 0 && errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== bench/zx_ports_stim.txt ====
# op(W/R/X) addr data dos keys_in kj_in mus_in tape_read sd_dataout expected check
# check 1 dout 2 hit/dataout 3 bc1/bdir 4 sd_datain 5 sd_start 6 beeper 7 border 8 p7ffd 9 peff7 a sdcs_n b 1m_on/ram0 c page
X 0000 00 0 1f 00 ff 0 ff 10 8
X 0000 00 0 1f 00 ff 0 ff 01 a
R 00fe 00 0 15 00 ff 1 ff d5 1
R 001f 00 0 1f 0a ff 0 ff 0a 1
R 00df 00 0 1f 00 3c 0 ff 3c 1
R 0077 00 0 1f 00 ff 0 ff 00 1
R 0057 00 0 1f 00 ff 0 a5 a5 1
R 0033 00 0 1f 00 ff 0 ff ff 1
R 00fe 00 0 1f 00 ff 0 ff 03 2
R fffd 00 0 1f 00 ff 0 ff 02 2
R 001f 00 1 1f 00 ff 0 ff 00 2
R fffd 00 0 1f 00 ff 0 ff 02 3
W fffd 07 0 1f 00 ff 0 ff 03 3
W bffd 55 0 1f 00 ff 0 ff 01 3
W 00fe 05 0 1f 00 ff 0 ff 01 6
W 00f6 02 0 1f 00 ff 0 ff 00 6
X 0000 00 0 1f 00 ff 0 ff 0a 7
W 7ffd e7 0 1f 00 ff 0 ff e7 8
W eff7 fe 0 1f 00 ff 0 ff b0 9
X 0000 00 0 1f 00 ff 0 ff 07 8
W 7ffd 00 0 1f 00 ff 0 ff 3f c
W eff7 00 1 1f 00 ff 0 ff b0 9
W fff7 00 0 1f 00 ff 0 ff 01 b
W eff7 00 0 1f 00 ff 0 ff e7 8
W 0077 00 0 1f 00 ff 0 ff 00 a
W 8057 02 1 1f 00 ff 0 ff 01 a
W 0057 3c 0 1f 00 ff 0 ff 01 5
W 0057 3c 0 1f 00 ff 0 ff 3c 4
R 0057 00 0 1f 00 ff 0 ff ff 4
R 0057 00 0 1f 00 ff 0 ff 01 5

// ==== build.f ====
verilog/zx_ports_pkg.sv
verilog/port_bus_if.sv
verilog/io_decode.sv
verilog/paging_regs.sv
verilog/audio_border.sv
verilog/sd_card_ctrl.sv
verilog/zx_ports.sv
bench/tb_zx_ports.sv

// ==== Makefile ====
VERILATOR  = verilator
SIM_FLAGS  = --binary
LINT_FLAGS = --lint-only --timing
TOP        = tb_zx_ports
RTL_TOP    = zx_ports
FILELIST   = build.f
BUILD_DIR  = obj_dir
PASS_MSG   = ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
